/* periph_pkg.sv */
// Shared definitions of the peripheral subsystem
// Bus widths, slot address map, slot and register selectors,
// and the data word returned with an error response

`default_nettype none

package periph_pkg;

    // ------------------------------------------------------------------------
    // Bus
    // ------------------------------------------------------------------------
    localparam int NumSlots  = 4;
    localparam int AddrWidth = 32;
    localparam int DataWidth = 32;

    // Slot order follows the interrupt source order
    typedef enum logic [1:0] {
        SLOT_UART = 2'd0,
        SLOT_SPI  = 2'd1,
        SLOT_ETH  = 2'd2,
        SLOT_GPIO = 2'd3
    } slot_e;

    // Register select, address bits 3:2
    typedef enum logic [1:0] {
        REG_OUT      = 2'd0,
        REG_IN       = 2'd1,
        REG_IRQ_EN   = 2'd2,
        REG_IRQ_STAT = 2'd3
    } reg_e;

    // ------------------------------------------------------------------------
    // Address map
    // ------------------------------------------------------------------------
    // Index 0 is the UART slot
    localparam logic [NumSlots-1:0][AddrWidth-1:0] SlotBase = {
        32'h4000_0000,
        32'h3000_0000,
        32'h2000_0000,
        32'h1000_0000
    };
    localparam logic [AddrWidth-1:0] SlotLength = 32'h0000_1000;

    localparam logic [DataWidth-1:0] ErrData = 32'hDEAD_BEEF;

endpackage

`default_nettype wire

/* addr_decoder.sv */
// Address decoder of the peripheral subsystem
// Registers each request and turns its address into a one-hot slot
// request, or into a miss when no slot range matches

`timescale 1ns/100ps
`default_nettype none

module addr_decoder (
    input  logic                                clk_i,
    input  logic                                rst_n_i,
    input  logic                                req_i,
    input  logic                                we_i,
    input  logic [periph_pkg::AddrWidth-1:0]    addr_i,
    input  logic [periph_pkg::DataWidth-1:0]    wdata_i,
    output logic [periph_pkg::NumSlots-1:0]     slot_req_o,
    output logic                                we_o,
    output periph_pkg::reg_e                    reg_o,
    output logic [periph_pkg::DataWidth-1:0]    wdata_o,
    output logic                                miss_o
);
    import periph_pkg::*;

    logic [NumSlots-1:0] hit;

    // ------------------------------------------------------------------------
    // Range compare
    // ------------------------------------------------------------------------
    // Last byte of a range is base plus length minus one
    always_comb begin
        for (int s = 0; s < NumSlots; s++) begin
            hit[s] = (addr_i >= SlotBase[s]) &&
                     (addr_i <= SlotBase[s] + (SlotLength - 1));
        end
    end

    // ------------------------------------------------------------------------
    // Request registers
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            slot_req_o <= '0;
            miss_o     <= 1'b0;
        end else begin
            slot_req_o <= req_i ? hit : '0;
            miss_o     <= req_i && (hit == '0);
        end
    end

    // Payload follows the request
    always_ff @(posedge clk_i) begin
        if (req_i) begin
            we_o    <= we_i;
            reg_o   <= reg_e'(addr_i[3:2]);
            wdata_o <= wdata_i;
        end
    end

endmodule

`default_nettype wire

/* periph_slot.sv */
// One peripheral slot
// Enabled slot holds output, input sample and interrupt enable
// registers and raises a level interrupt from the masked input
// Disabled slot is an error responder with fixed read data and no state

`timescale 1ns/100ps
`default_nettype none

module periph_slot #(
    parameter bit Enable    = 1'b1,
    parameter int GpioWidth = 8
) (
    input  logic                                clk_i,
    input  logic                                rst_n_i,
    input  logic                                req_i,
    input  logic                                we_i,
    input  periph_pkg::reg_e                    reg_i,
    input  logic [periph_pkg::DataWidth-1:0]    wdata_i,
    input  logic [GpioWidth-1:0]                gpio_i,
    output logic [GpioWidth-1:0]                gpio_o,
    output logic                                irq_o,
    output logic                                rsp_valid_o,
    output logic [periph_pkg::DataWidth-1:0]    rsp_rdata_o,
    output logic                                rsp_err_o
);
    import periph_pkg::*;

    logic rsp_valid_q;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            rsp_valid_q <= 1'b0;
        end else begin
            rsp_valid_q <= req_i;
        end
    end

    assign rsp_valid_o = rsp_valid_q;

    if (Enable) begin : gen_regs
        logic [GpioWidth-1:0] out_q;
        logic [GpioWidth-1:0] in_q;
        logic [GpioWidth-1:0] irq_en_q;
        logic [GpioWidth-1:0] irq_stat;
        logic [DataWidth-1:0] rdata_d;
        logic [DataWidth-1:0] rdata_q;

        assign irq_stat = in_q & irq_en_q;

        // --------------------------------------------------------------------
        // Register file
        // --------------------------------------------------------------------
        always_ff @(posedge clk_i) begin
            if (!rst_n_i) begin
                out_q    <= '0;
                in_q     <= '0;
                irq_en_q <= '0;
            end else begin
                in_q <= gpio_i;
                if (req_i && we_i) begin
                    case (reg_i)
                        REG_OUT:    out_q    <= wdata_i[GpioWidth-1:0];
                        REG_IRQ_EN: irq_en_q <= wdata_i[GpioWidth-1:0];
                        default:    ;
                    endcase
                end
            end
        end

        // Read mux returns zero on writes
        always_comb begin
            rdata_d = '0;
            if (!we_i) begin
                case (reg_i)
                    REG_OUT:      rdata_d[GpioWidth-1:0] = out_q;
                    REG_IN:       rdata_d[GpioWidth-1:0] = in_q;
                    REG_IRQ_EN:   rdata_d[GpioWidth-1:0] = irq_en_q;
                    REG_IRQ_STAT: rdata_d[GpioWidth-1:0] = irq_stat;
                    default:      rdata_d = '0;
                endcase
            end
        end

        always_ff @(posedge clk_i) begin
            if (req_i) begin
                rdata_q <= rdata_d;
            end
        end

        assign gpio_o      = out_q;
        assign irq_o       = |irq_stat;
        assign rsp_rdata_o = rdata_q;
        assign rsp_err_o   = 1'b0;
    end else begin : gen_err
        // Every access fails and nothing is stored
        assign gpio_o      = '0;
        assign irq_o       = 1'b0;
        assign rsp_rdata_o = ErrData;
        assign rsp_err_o   = 1'b1;
    end

endmodule

`default_nettype wire

/* rsp_collect.sv */
// Response collector
// Merges the slot responses into one response port and turns a
// decoder miss, delayed to line up with the slots, into an error

`timescale 1ns/100ps
`default_nettype none

module rsp_collect (
    input  logic                                                    clk_i,
    input  logic                                                    rst_n_i,
    input  logic [periph_pkg::NumSlots-1:0]                         slot_valid_i,
    input  logic [periph_pkg::NumSlots-1:0][periph_pkg::DataWidth-1:0] slot_rdata_i,
    input  logic [periph_pkg::NumSlots-1:0]                         slot_err_i,
    input  logic                                                    miss_i,
    output logic                                                    rsp_valid_o,
    output logic [periph_pkg::DataWidth-1:0]                        rdata_o,
    output logic                                                    err_o
);
    import periph_pkg::*;

    logic miss_q;

    // Same latency as a slot
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            miss_q <= 1'b0;
        end else begin
            miss_q <= miss_i;
        end
    end

    // ------------------------------------------------------------------------
    // Merge
    // ------------------------------------------------------------------------
    // At most one source is valid per cycle, so an AND-OR mux is enough
    always_comb begin
        rdata_o = '0;
        err_o   = 1'b0;
        for (int s = 0; s < NumSlots; s++) begin
            if (slot_valid_i[s]) begin
                rdata_o = rdata_o | slot_rdata_i[s];
                err_o   = err_o | slot_err_i[s];
            end
        end
        if (miss_q) begin
            rdata_o = ErrData;
            err_o   = 1'b1;
        end
    end

    assign rsp_valid_o = (|slot_valid_i) | miss_q;

endmodule

`default_nettype wire

/* periph_subsystem.sv */
// Peripheral subsystem top level
// Address decoder, one slot per peripheral region, response collector

`timescale 1ns/100ps
`default_nettype none

module periph_subsystem #(
    // UART and GPIO enabled by default
    parameter logic [periph_pkg::NumSlots-1:0] SlotEnable =
        (4'b1 << periph_pkg::SLOT_UART) | (4'b1 << periph_pkg::SLOT_GPIO),
    parameter int GpioWidth = 8
) (
    input  logic                                            clk_i,
    input  logic                                            rst_n_i,
    input  logic                                            req_i,
    input  logic                                            we_i,
    input  logic [periph_pkg::AddrWidth-1:0]                addr_i,
    input  logic [periph_pkg::DataWidth-1:0]                wdata_i,
    input  logic [periph_pkg::NumSlots-1:0][GpioWidth-1:0]  gpio_i,
    output logic [periph_pkg::NumSlots-1:0][GpioWidth-1:0]  gpio_o,
    output logic [periph_pkg::NumSlots-1:0]                 irq_o,
    output logic                                            rsp_valid_o,
    output logic [periph_pkg::DataWidth-1:0]                rdata_o,
    output logic                                            err_o
);
    import periph_pkg::*;

    logic [NumSlots-1:0]                slot_req;
    logic                               slot_we;
    reg_e                               slot_reg;
    logic [DataWidth-1:0]               slot_wdata;
    logic                               miss;
    logic [NumSlots-1:0]                slot_valid;
    logic [NumSlots-1:0][DataWidth-1:0] slot_rdata;
    logic [NumSlots-1:0]                slot_err;

    addr_decoder u_decoder (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .req_i      (req_i),
        .we_i       (we_i),
        .addr_i     (addr_i),
        .wdata_i    (wdata_i),
        .slot_req_o (slot_req),
        .we_o       (slot_we),
        .reg_o      (slot_reg),
        .wdata_o    (slot_wdata),
        .miss_o     (miss)
    );

    // ------------------------------------------------------------------------
    // Slots
    // ------------------------------------------------------------------------
    for (genvar s = 0; s < NumSlots; s++) begin : gen_slot
        periph_slot #(
            .Enable    (SlotEnable[s]),
            .GpioWidth (GpioWidth)
        ) u_slot (
            .clk_i       (clk_i),
            .rst_n_i     (rst_n_i),
            .req_i       (slot_req[s]),
            .we_i        (slot_we),
            .reg_i       (slot_reg),
            .wdata_i     (slot_wdata),
            .gpio_i      (gpio_i[s]),
            .gpio_o      (gpio_o[s]),
            .irq_o       (irq_o[s]),
            .rsp_valid_o (slot_valid[s]),
            .rsp_rdata_o (slot_rdata[s]),
            .rsp_err_o   (slot_err[s])
        );
    end

    rsp_collect u_collect (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .slot_valid_i (slot_valid),
        .slot_rdata_i (slot_rdata),
        .slot_err_i   (slot_err),
        .miss_i       (miss),
        .rsp_valid_o  (rsp_valid_o),
        .rdata_o      (rdata_o),
        .err_o        (err_o)
    );

endmodule

`default_nettype wire

/* tb_periph_subsystem.sv */
// Testbench for the peripheral subsystem
// Reference model function, request queue and a comparing process
// that checks every response two cycles after its request

`timescale 1ns/100ps
`default_nettype none

module tb_periph_subsystem;
    import periph_pkg::*;

    localparam int GW = 8;
    // UART and GPIO slots enabled
    localparam logic [3:0] EN_VEC = 4'b1001;
    localparam logic [31:0] MAP_LEN = 32'h0000_1000;

    logic clk_i;
    logic rst_n_i;
    logic req_i;
    logic we_i;
    logic [31:0] addr_i;
    logic [31:0] wdata_i;
    logic [3:0][GW-1:0] gpio_i;
    logic [3:0][GW-1:0] gpio_o;
    logic [3:0] irq_o;
    logic rsp_valid_o;
    logic [31:0] rdata_o;
    logic err_o;

    // Model state per slot
    logic [GW-1:0] out_m [4];
    logic [GW-1:0] en_m [4];
    logic [GW-1:0] pin_m [4];
    logic [32:0] exp_q [$];
    int issue_q [$];
    int cyc;
    int n_mismatch;
    int n_other;
    int n_checked;
    integer seed;

    periph_subsystem u_dut (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .req_i       (req_i),
        .we_i        (we_i),
        .addr_i      (addr_i),
        .wdata_i     (wdata_i),
        .gpio_i      (gpio_i),
        .gpio_o      (gpio_o),
        .irq_o       (irq_o),
        .rsp_valid_o (rsp_valid_o),
        .rdata_o     (rdata_o),
        .err_o       (err_o)
    );

    always #10 clk_i = ~clk_i;

    function automatic logic [31:0] base_of(input int s);
        return 32'h1000_0000 * (s + 1);
    endfunction

    // Returns the expected {err, rdata} and updates the model on writes
    function automatic logic [32:0] ref_access(input logic [3:0] en, input logic we,
                                               input logic [31:0] addr, input logic [31:0] wdata);
        int slot;
        logic [31:0] rd;
        slot = -1;
        for (int s = 0; s < 4; s++) begin
            if (addr >= base_of(s) && addr <= base_of(s) + MAP_LEN - 32'd1) begin
                slot = s;
            end
        end
        if (slot < 0 || !en[slot]) begin
            return {1'b1, 32'hDEAD_BEEF};
        end
        rd = '0;
        if (we) begin
            case (reg_e'(addr[3:2]))
                REG_OUT:    out_m[slot] = wdata[GW-1:0];
                REG_IRQ_EN: en_m[slot] = wdata[GW-1:0];
                default:    ;
            endcase
        end else begin
            case (reg_e'(addr[3:2]))
                REG_OUT:      rd[GW-1:0] = out_m[slot];
                REG_IN:       rd[GW-1:0] = pin_m[slot];
                REG_IRQ_EN:   rd[GW-1:0] = en_m[slot];
                REG_IRQ_STAT: rd[GW-1:0] = pin_m[slot] & en_m[slot];
            endcase
        end
        return {1'b0, rd};
    endfunction

    task automatic send(input logic we, input logic [31:0] addr, input logic [31:0] wdata);
        @(posedge clk_i);
        req_i   <= 1'b1;
        we_i    <= we;
        addr_i  <= addr;
        wdata_i <= wdata;
        exp_q.push_back(ref_access(EN_VEC, we, addr, wdata));
        issue_q.push_back(cyc);
    endtask

    // Stop requesting and wait until every response has come back
    task automatic drain();
        int t;
        @(posedge clk_i);
        req_i <= 1'b0;
        t = 0;
        while (exp_q.size() > 0 && t < 20) begin
            @(negedge clk_i);
            t++;
        end
        if (exp_q.size() > 0) begin
            $display("ERROR: timeout with %0d responses outstanding", exp_q.size());
            n_other++;
            exp_q.delete();
            issue_q.delete();
        end
    endtask

    task automatic set_pins(input logic [3:0][GW-1:0] v);
        @(posedge clk_i);
        gpio_i <= v;
        // Input sample register needs a cycle
        repeat (3) @(posedge clk_i);
        for (int s = 0; s < 4; s++) begin
            pin_m[s] = v[s];
        end
    endtask

    task automatic check_outputs();
        logic [GW-1:0] exp_gpio;
        logic exp_irq;
        @(negedge clk_i);
        for (int s = 0; s < 4; s++) begin
            exp_gpio = EN_VEC[s] ? out_m[s] : '0;
            exp_irq  = EN_VEC[s] && ((pin_m[s] & en_m[s]) != '0);
            if (gpio_o[s] !== exp_gpio) begin
                $display("MISMATCH gpio_o[%0d]: got %h, expected %h", s, gpio_o[s], exp_gpio);
                n_mismatch++;
            end
            if (irq_o[s] !== exp_irq) begin
                $display("MISMATCH irq_o[%0d]: got %h, expected %h", s, irq_o[s], exp_irq);
                n_mismatch++;
            end
        end
    endtask

    task automatic write_read_back(input int s, input logic [31:0] out_v, input logic [31:0] en_v);
        send(1'b1, base_of(s), out_v);
        send(1'b1, base_of(s) + 32'd8, en_v);
        send(1'b0, base_of(s), 32'd0);
        send(1'b0, base_of(s) + 32'd8, 32'd0);
    endtask

    // ------------------------------------------------------------------------
    // Response checker
    // ------------------------------------------------------------------------
    always @(negedge clk_i) begin : check_rsp
        logic [32:0] exp_rsp;
        int iss;
        if (rst_n_i) begin
            if (rsp_valid_o) begin
                if (exp_q.size() == 0) begin
                    $display("ERROR: response at cycle %0d with no request outstanding", cyc);
                    n_other++;
                end else begin
                    exp_rsp = exp_q.pop_front();
                    iss = issue_q.pop_front();
                    n_checked++;
                    if (cyc != iss + 2) begin
                        $display("ERROR: response at cycle %0d for request of cycle %0d", cyc, iss);
                        n_other++;
                    end
                    if (rdata_o !== exp_rsp[31:0]) begin
                        $display("MISMATCH rdata_o: got %h, expected %h", rdata_o, exp_rsp[31:0]);
                        n_mismatch++;
                    end
                    if (err_o !== exp_rsp[32]) begin
                        $display("MISMATCH err_o: got %h, expected %h", err_o, exp_rsp[32]);
                        n_mismatch++;
                    end
                end
            end else if (issue_q.size() > 0 && cyc >= issue_q[0] + 2) begin
                $display("ERROR: no response for request of cycle %0d", issue_q[0]);
                n_other++;
                exp_rsp = exp_q.pop_front();
                iss = issue_q.pop_front();
            end
        end
        cyc++;
    end

    initial begin
        int sel;
        logic [31:0] r;
        logic [31:0] a;
        seed = 62981;
        clk_i = 1'b0;
        rst_n_i = 1'b0;
        req_i = 1'b0;
        we_i = 1'b0;
        addr_i = '0;
        wdata_i = '0;
        gpio_i = '0;
        cyc = 0;
        n_mismatch = 0;
        n_other = 0;
        n_checked = 0;
        for (int s = 0; s < 4; s++) begin
            out_m[s] = '0;
            en_m[s] = '0;
            pin_m[s] = '0;
        end
        repeat (10) @(posedge clk_i);
        rst_n_i <= 1'b1;
        check_outputs();
        if (rsp_valid_o !== 1'b0) begin
            $display("MISMATCH rsp_valid_o: got %h, expected 0", rsp_valid_o);
            n_mismatch++;
        end

        // Enabled slots followed by disabled ones
        write_read_back(0, 32'hA5A5_A5C3, 32'h0000_00F0);
        write_read_back(3, 32'h1234_5666, 32'h0000_000F);
        drain();
        check_outputs();
        write_read_back(1, 32'h0000_00FF, 32'h0000_00FF);
        write_read_back(2, 32'h0000_0011, 32'h0000_0022);
        send(1'b0, base_of(1) + 32'd4, 32'd0);
        drain();
        check_outputs();

        // Unmapped addresses
        send(1'b0, 32'h5000_0000, 32'd0);
        send(1'b1, base_of(0) + MAP_LEN, 32'h0000_0077);
        send(1'b0, base_of(3) + MAP_LEN + 32'd4, 32'd0);
        send(1'b0, 32'h0FFF_FFFC, 32'd0);
        drain();

        // Inputs and interrupts
        set_pins({8'h3C, 8'h55, 8'hAA, 8'h96});
        for (int s = 0; s < 4; s += 3) begin
            send(1'b0, base_of(s) + 32'd4, 32'd0);
            send(1'b1, base_of(s) + 32'd8, (s == 0) ? 32'h0F : 32'hC3);
            send(1'b0, base_of(s) + 32'd12, 32'd0);
        end
        drain();
        check_outputs();
        send(1'b1, base_of(3) + 32'd8, 32'h0000_000C);
        send(1'b0, base_of(3) + 32'd12, 32'd0);
        drain();
        check_outputs();

        // Random back-to-back burst
        for (int i = 0; i < 200; i++) begin
            sel = $unsigned($random(seed)) % 6;
            r = $random(seed);
            if (sel < 4) begin
                a = base_of(sel) + (r & 32'h0000_0FFC);
            end else if (sel == 4) begin
                a = 32'h5000_0000 + (r & 32'h0000_FFFC);
            end else begin
                a = base_of(int'(r[1:0])) + MAP_LEN + (r & 32'h0000_00FC);
            end
            send(r[31], a, $random(seed));
        end
        drain();
        check_outputs();

        $display("checked %0d responses, %0d mismatches, %0d other errors",
                 n_checked, n_mismatch, n_other);
        if (n_mismatch == 0 && n_other == 0 && n_checked > 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
periph_pkg.sv
addr_decoder.sv
periph_slot.sv
rsp_collect.sv
periph_subsystem.sv
tb_periph_subsystem.sv

/* Makefile */
# Verilator build and run of the peripheral subsystem testbench

VERILATOR ?= verilator
TOP       ?= tb_periph_subsystem
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --timescale 1ns/100ps

SRCS := $(shell grep -v '^+' $(FLIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "sim failed" $(LOG); then echo "FAIL"; exit 1; fi
	@if ! grep -q "sim passed" $(LOG); then echo "FAIL: no result line"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
